// File: verilog.f
+incdir+verilog
verilog/core_pkg.sv
verilog/stage_if.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_unit.sv
verilog/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/core_tb_sim 2>&1 | tee sim.log

grep -qF "*** FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; } \
    || grep -qF "*** PASSED ***" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }

// File: tests/core_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb import core_pkg::*; ();
    localparam logic [31:0] MARKER = 32'h0000_03fc;

    logic        clk_wfi;
    logic        rstn_sync;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        dmem_en_o;
    logic        dmem_write_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [31:0] dmem_rdata_i;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng = 32'hc63a7d78;
    int          st_idx;
    logic        done;

    core_top core_top_inst (.*);

    bind core_top core_assert core_assert_inst (.*);

    // Both memories answer in the same cycle
    assign imem_rdata_i = imem[imem_addr_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

    initial begin
        clk_wfi = 1'b0;
        forever #5 clk_wfi = ~clk_wfi;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Data memory contents before a run
    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        return (idx * 32'h9e37_79b1) ^ (idx << 16) ^ 32'h1357_2468;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_op(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [31:0] imm, input opcode_e op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [31:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] br(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [31:0] upper);
        return {upper[19:0], rd, OPC_LUI};
    endfunction

    // Architectural model, one instruction per step
    function automatic logic iss_run();
        logic [31:0] rf [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic        fin;
        logic        wr;
        fin = 1'b0;
        pc  = `RESET_PC;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        for (int step = 0; step < 2000 && !fin; step++) begin
            inst    = imem[pc[9:2]];
            a       = rf[inst[19:15]];
            b       = rf[inst[24:20]];
            next_pc = pc + 4;
            wr      = 1'b1;
            res     = '0;
            case (opcode_e'(inst[6:0]))
                OPC_OP_IMM, OPC_OP: begin
                    if (inst[6:0] == OPC_OP_IMM) begin
                        b = {{20{inst[31]}}, inst[31:20]};
                    end
                    case (inst[14:12])
                        3'b000: res = (inst[6:0] == OPC_OP && inst[30]) ? a - b : a + b;
                        3'b010: res = {31'b0, $signed(a) < $signed(b)};
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                OPC_LUI: res = {inst[31:12], 12'b0};
                OPC_LOAD: res = mem[(a + {{20{inst[31]}}, inst[31:20]}) >> 2 & 32'hff];
                OPC_STORE: begin
                    wr   = 1'b0;
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    mem[addr[9:2]] = b;
                    fin = (addr == MARKER);
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) ^ inst[12]) begin
                        next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    res     = pc + 4;
                    next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                rf[inst[11:7]] = res;
            end
            pc = next_pc;
        end
        return fin;
    endfunction

    // Log and compare every store of the DUT
    always @(posedge clk_wfi) begin
        if (!rstn_sync) begin
            st_idx <= 0;
            done   <= 1'b0;
            // Data memory refills while reset is held
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_en_o && dmem_write_o) begin
            dmem[dmem_addr_o[9:2]] <= dmem_wdata_o;
            if (st_idx >= exp_addr.size()) begin
                report_fail("The DUT made more stores than the reference model");
            end else begin
                check_value(dmem_addr_o, exp_addr[st_idx], "store address");
                check_value(dmem_wdata_o, exp_data[st_idx], "store data");
                st_idx <= st_idx + 1;
                if (dmem_addr_o == MARKER) begin
                    done <= 1'b1;
                end
            end
        end
    end

    task automatic run_program(input string name);
        int cnt;
        @(posedge clk_wfi);
        rstn_sync <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : `INST_NOP;
        end
        if (!iss_run()) begin
            report_fail("Reference model never reached the final store");
        end
        repeat (16) @(posedge clk_wfi);
        rstn_sync <= 1'b1;
        cnt = 0;
        while (!done && cnt < 5000) begin
            @(posedge clk_wfi);
            cnt++;
        end
        if (!done) begin
            report_fail({"Timeout waiting for the final store of the ", name, " program"});
        end
        prog.delete();
    endtask

    task automatic build_directed();
        logic [31:0] alu [$];
        alu = '{i_op(3'b000, 1, 0, 100, OPC_OP_IMM), i_op(3'b000, 2, 1, -7, OPC_OP_IMM),
                r_op(7'h00, 3'b000, 3, 1, 2), r_op(7'h20, 3'b000, 4, 3, 1),
                r_op(7'h00, 3'b111, 5, 4, 3), r_op(7'h00, 3'b110, 6, 5, 2),
                r_op(7'h00, 3'b100, 7, 6, 1), r_op(7'h00, 3'b010, 8, 4, 7),
                lui(9, 32'habcde), i_op(3'b010, 10, 4, 2000, OPC_OP_IMM)};
        // Each result is stored right away
        foreach (alu[i]) begin
            prog.push_back(alu[i]);
            prog.push_back(sw(alu[i][11:7], 0, 32'h100 + i * 4));
        end
        prog.push_back(i_op(3'b010, 10, 0, 32'h40, OPC_LOAD));
        prog.push_back(i_op(3'b000, 11, 10, 25, OPC_OP_IMM));
        prog.push_back(sw(11, 0, 32'h140));
        prog.push_back(i_op(3'b010, 12, 0, 32'h44, OPC_LOAD));
        prog.push_back(r_op(7'h00, 3'b000, 13, 11, 12));
        prog.push_back(sw(13, 0, 32'h144));
        prog.push_back(i_op(3'b000, 14, 0, 5, OPC_OP_IMM));
        prog.push_back(i_op(3'b000, 15, 0, 5, OPC_OP_IMM));
        prog.push_back(lui(20, 32'hdead0));
        prog.push_back(br(3'b000, 14, 15, 12));
        prog.push_back(sw(20, 0, 32'h180));
        prog.push_back(sw(20, 0, 32'h184));
        prog.push_back(br(3'b001, 14, 15, 8));
        prog.push_back(sw(14, 0, 32'h188));
        prog.push_back(br(3'b000, 14, 0, 8));
        prog.push_back(sw(15, 0, 32'h18c));
        prog.push_back(br(3'b001, 14, 0, 12));
        prog.push_back(sw(20, 0, 32'h180));
        prog.push_back(sw(20, 0, 32'h184));
        prog.push_back(jal(21, 12));
        prog.push_back(sw(20, 0, 32'h180));
        prog.push_back(sw(20, 0, 32'h184));
        prog.push_back(sw(21, 0, 32'h190));
        // x0 keeps zero
        prog.push_back(i_op(3'b000, 0, 0, 55, OPC_OP_IMM));
        prog.push_back(r_op(7'h00, 3'b000, 0, 14, 15));
        prog.push_back(sw(0, 0, 32'h194));
        prog.push_back(sw(14, 0, MARKER));
        prog.push_back(jal(0, 0));
    endtask

    task automatic build_random();
        logic [31:0] r;
        logic [2:0]  f3s [6];
        int          sel;
        f3s = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        for (int i = 1; i < 32; i++) begin
            prog.push_back(lui(5'(i), xorshift()));
        end
        for (int i = 0; i < 40; i++) begin
            r   = xorshift();
            sel = r % 6;
            prog.push_back(r_op(sel == 1 ? 7'h20 : 7'h00, f3s[sel], r[8:4], r[13:9], r[18:14]));
        end
        for (int i = 1; i < 32; i++) begin
            prog.push_back(sw(5'(i), 0, 32'h200 + i * 4));
        end
        prog.push_back(sw(1, 0, MARKER));
        prog.push_back(jal(0, 0));
    endtask

    initial begin
        rstn_sync = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `INST_NOP;
        end
        build_directed();
        run_program("directed");
        build_random();
        run_program("random");
        $display("*** PASSED ***");
        $finish;
    end
endmodule

// File: tests/core_assert.sv
`timescale 1ns/1ps

module core_assert (
    input logic        clk_wfi,
    input logic        rstn_sync,
    input logic        dmem_en_o,
    input logic [31:0] dmem_addr_o,
    input logic [31:0] imem_addr_o
);
    // No data access while reset is held
    a_no_dmem_in_reset: assert property (@(posedge clk_wfi) !rstn_sync |-> !dmem_en_o)
        else $error("dmem_en_o high during reset");

    a_dmem_aligned: assert property (@(posedge clk_wfi) disable iff (!rstn_sync)
        dmem_en_o |-> dmem_addr_o[1:0] == 2'b00)
        else $error("dmem_addr_o not word aligned");

    a_imem_known: assert property (@(posedge clk_wfi) disable iff (!rstn_sync)
        !$isunknown(imem_addr_o))
        else $error("imem_addr_o unknown after reset");
endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top import core_pkg::*; (
    input  logic             clk_wfi,
    input  logic             rstn_sync,
    output logic [`XLEN-1:0] imem_addr_o,
    input  logic [`XLEN-1:0] imem_rdata_i,
    output logic             dmem_en_o,
    output logic             dmem_write_o,
    output logic [`XLEN-1:0] dmem_addr_o,
    output logic [`XLEN-1:0] dmem_wdata_o,
    input  logic [`XLEN-1:0] dmem_rdata_i
);
    logic                   if_valid;
    logic [`XLEN-1:0]       if_pc;
    logic [`XLEN-1:0]       if_inst;
    logic                   load_use_stall;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;

    // ID/EX
    logic                   id_valid;
    logic [`XLEN-1:0]       id_pc;
    logic [`REG_ADDR_W-1:0] id_rs1_addr;
    logic [`REG_ADDR_W-1:0] id_rs2_addr;
    logic [`XLEN-1:0]       id_rs1_data;
    logic [`XLEN-1:0]       id_rs2_data;
    logic [`REG_ADDR_W-1:0] id_rd_addr;
    logic                   id_rd_wr;
    logic [`XLEN-1:0]       id_imm;
    alu_op_e                id_alu_op;
    logic                   id_use_imm;
    logic                   id_is_load;
    logic                   id_is_store;
    logic                   id_is_branch;
    logic                   id_branch_ne;
    logic                   id_is_jal;

    // Writeback bus
    logic                   wb_rd_wr;
    logic [`REG_ADDR_W-1:0] wb_rd_addr;
    logic [`XLEN-1:0]       wb_rd_data;

    stage_if ex2mem ();

    fetch_unit fetch_unit_inst (
        .clk_wfi       (clk_wfi),
        .rstn_sync     (rstn_sync),
        .stall_i       (load_use_stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_inst_o     (if_inst)
    );

    decode_unit decode_unit_inst (
        .clk_wfi          (clk_wfi),
        .rstn_sync        (rstn_sync),
        .if_valid_i       (if_valid),
        .if_pc_i          (if_pc),
        .if_inst_i        (if_inst),
        .flush_i          (redirect),
        .wb_rd_wr_i       (wb_rd_wr),
        .wb_rd_addr_i     (wb_rd_addr),
        .wb_rd_data_i     (wb_rd_data),
        .load_use_stall_o (load_use_stall),
        .valid_o          (id_valid),
        .pc_o             (id_pc),
        .rs1_addr_o       (id_rs1_addr),
        .rs2_addr_o       (id_rs2_addr),
        .rs1_data_o       (id_rs1_data),
        .rs2_data_o       (id_rs2_data),
        .rd_addr_o        (id_rd_addr),
        .rd_wr_o          (id_rd_wr),
        .imm_o            (id_imm),
        .alu_op_o         (id_alu_op),
        .use_imm_o        (id_use_imm),
        .is_load_o        (id_is_load),
        .is_store_o       (id_is_store),
        .is_branch_o      (id_is_branch),
        .branch_ne_o      (id_branch_ne),
        .is_jal_o         (id_is_jal)
    );

    execute_unit execute_unit_inst (
        .clk_wfi       (clk_wfi),
        .rstn_sync     (rstn_sync),
        .valid_i       (id_valid),
        .pc_i          (id_pc),
        .rs1_addr_i    (id_rs1_addr),
        .rs2_addr_i    (id_rs2_addr),
        .rs1_data_i    (id_rs1_data),
        .rs2_data_i    (id_rs2_data),
        .rd_addr_i     (id_rd_addr),
        .rd_wr_i       (id_rd_wr),
        .imm_i         (id_imm),
        .alu_op_i      (id_alu_op),
        .use_imm_i     (id_use_imm),
        .is_load_i     (id_is_load),
        .is_store_i    (id_is_store),
        .is_branch_i   (id_is_branch),
        .branch_ne_i   (id_branch_ne),
        .is_jal_i      (id_is_jal),
        .wb_rd_wr_i    (wb_rd_wr),
        .wb_rd_addr_i  (wb_rd_addr),
        .wb_rd_data_i  (wb_rd_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex2mem        (ex2mem.src)
    );

    mem_unit mem_unit_inst (
        .clk_wfi      (clk_wfi),
        .rstn_sync    (rstn_sync),
        .ex2mem       (ex2mem.dst),
        .dmem_en_o    (dmem_en_o),
        .dmem_write_o (dmem_write_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_rd_wr_o   (wb_rd_wr),
        .wb_rd_addr_o (wb_rd_addr),
        .wb_rd_data_o (wb_rd_data)
    );
endmodule

// File: verilog/mem_unit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_unit (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    stage_if.dst                   ex2mem,
    output logic                   dmem_en_o,
    output logic                   dmem_write_o,
    output logic [`XLEN-1:0]       dmem_addr_o,
    output logic [`XLEN-1:0]       dmem_wdata_o,
    input  logic [`XLEN-1:0]       dmem_rdata_i,
    output logic                   wb_rd_wr_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [`XLEN-1:0]       wb_rd_data_o
);
    logic is_load;

    assign is_load      = ex2mem.mem_req & ~ex2mem.mem_wr;
    assign dmem_en_o    = ex2mem.valid & ex2mem.mem_req;
    assign dmem_write_o = ex2mem.valid & ex2mem.mem_req & ex2mem.mem_wr;
    assign dmem_addr_o  = ex2mem.result;
    assign dmem_wdata_o = ex2mem.store_data;

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            wb_rd_wr_o <= 1'b0;
        end else begin
            wb_rd_wr_o <= ex2mem.valid & ex2mem.rd_wr;
        end
    end

    // Data memory answers in the same cycle
    always_ff @(posedge clk_wfi) begin
        wb_rd_addr_o <= ex2mem.rd_addr;
        wb_rd_data_o <= is_load ? dmem_rdata_i : ex2mem.result;
    end
endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_unit import core_pkg::*; (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    input  logic                   valid_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic                   rd_wr_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  alu_op_e                alu_op_i,
    input  logic                   use_imm_i,
    input  logic                   is_load_i,
    input  logic                   is_store_i,
    input  logic                   is_branch_i,
    input  logic                   branch_ne_i,
    input  logic                   is_jal_i,
    input  logic                   wb_rd_wr_i,
    input  logic [`REG_ADDR_W-1:0] wb_rd_addr_i,
    input  logic [`XLEN-1:0]       wb_rd_data_i,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    stage_if.src                   ex2mem
);
    logic             mem_fwd_ok;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic             taken;

    // Load data is not ready in EX/MEM, decode stalls for that case
    assign mem_fwd_ok = ex2mem.rd_wr & ~(ex2mem.mem_req & ~ex2mem.mem_wr);

    function automatic logic [`XLEN-1:0] fwd(input logic [`REG_ADDR_W-1:0] addr,
                                             input logic [`XLEN-1:0] reg_val);
        if (addr == '0) begin
            return reg_val;
        end else if (mem_fwd_ok && ex2mem.rd_addr == addr) begin
            return ex2mem.result;
        end else if (wb_rd_wr_i && wb_rd_addr_i == addr) begin
            return wb_rd_data_i;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a    = fwd(rs1_addr_i, rs1_data_i);
        rs2_val = fwd(rs2_addr_i, rs2_data_i);
    end

    assign op_b    = use_imm_i ? imm_i : rs2_val;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    assign taken         = is_branch_i & ((op_a == rs2_val) ^ branch_ne_i);
    assign redirect_o    = valid_i & (taken | is_jal_i);
    assign redirect_pc_o = pc_i + imm_i;

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            ex2mem.valid   <= 1'b0;
            ex2mem.rd_wr   <= 1'b0;
            ex2mem.mem_req <= 1'b0;
            ex2mem.mem_wr  <= 1'b0;
        end else begin
            ex2mem.valid   <= valid_i;
            ex2mem.rd_wr   <= rd_wr_i;
            ex2mem.mem_req <= is_load_i | is_store_i;
            ex2mem.mem_wr  <= is_store_i;
        end
    end

    // Link address replaces the ALU result for JAL
    always_ff @(posedge clk_wfi) begin
        ex2mem.rd_addr    <= rd_addr_i;
        ex2mem.result     <= is_jal_i ? pc_i + `XLEN'd4 : alu_res;
        ex2mem.store_data <= rs2_val;
    end
endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_unit import core_pkg::*; (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    input  logic                   if_valid_i,
    input  logic [`XLEN-1:0]       if_pc_i,
    input  logic [`XLEN-1:0]       if_inst_i,
    input  logic                   flush_i,
    input  logic                   wb_rd_wr_i,
    input  logic [`REG_ADDR_W-1:0] wb_rd_addr_i,
    input  logic [`XLEN-1:0]       wb_rd_data_i,
    output logic                   load_use_stall_o,
    output logic                   valid_o,
    output logic [`XLEN-1:0]       pc_o,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output logic                   rd_wr_o,
    output logic [`XLEN-1:0]       imm_o,
    output alu_op_e                alu_op_o,
    output logic                   use_imm_o,
    output logic                   is_load_o,
    output logic                   is_store_o,
    output logic                   is_branch_o,
    output logic                   branch_ne_o,
    output logic                   is_jal_o
);
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       imm;
    alu_op_e                f3_op;
    alu_op_e                alu_op;
    logic                   rd_wr;
    logic                   use_imm;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   is_load;
    logic                   is_store;
    logic                   is_branch;
    logic                   is_jal;
    logic                   dec_ok;

    assign opcode = opcode_e'(if_inst_i[6:0]);
    assign funct3 = if_inst_i[14:12];
    assign rs1    = if_inst_i[19:15];
    assign rs2    = if_inst_i[24:20];

    reg_file reg_file_inst (
        .clk_wfi    (clk_wfi),
        .rstn_sync  (rstn_sync),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_val),
        .rs2_data_o (rs2_val),
        .wr_i       (wb_rd_wr_i),
        .wr_addr_i  (wb_rd_addr_i),
        .wr_data_i  (wb_rd_data_i)
    );

    // Shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = '0;
        rd_wr     = 1'b0;
        use_imm   = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                {rd_wr, use_imm, uses_rs1} = 3'b111;
                alu_op = f3_op;
                imm    = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
            end
            OPC_OP: begin
                {rd_wr, uses_rs1, uses_rs2} = 3'b111;
                alu_op = (funct3 == 3'b000 && if_inst_i[30]) ? ALU_SUB : f3_op;
            end
            OPC_LUI: begin
                {rd_wr, use_imm} = 2'b11;
                alu_op = ALU_PASS_B;
                imm    = {if_inst_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                {rd_wr, use_imm, uses_rs1, is_load} = 4'b1111;
                imm = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
            end
            OPC_STORE: begin
                {use_imm, uses_rs1, uses_rs2, is_store} = 4'b1111;
                imm = {{20{if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
            end
            OPC_BRANCH: begin
                {uses_rs1, uses_rs2, is_branch} = 3'b111;
                imm = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                       if_inst_i[30:25], if_inst_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                {rd_wr, is_jal} = 2'b11;
                imm = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                       if_inst_i[20], if_inst_i[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // Load in execute whose rd feeds this instruction
    assign load_use_stall_o = if_valid_i && is_load_o && rd_addr_o != '0 &&
                              ((uses_rs1 && rs1 == rd_addr_o) || (uses_rs2 && rs2 == rd_addr_o));

    assign dec_ok = if_valid_i & ~flush_i & ~load_use_stall_o;

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            valid_o     <= 1'b0;
            rd_wr_o     <= 1'b0;
            is_load_o   <= 1'b0;
            is_store_o  <= 1'b0;
            is_branch_o <= 1'b0;
            is_jal_o    <= 1'b0;
        end else begin
            valid_o     <= dec_ok;
            rd_wr_o     <= dec_ok & rd_wr;
            is_load_o   <= dec_ok & is_load;
            is_store_o  <= dec_ok & is_store;
            is_branch_o <= dec_ok & is_branch;
            is_jal_o    <= dec_ok & is_jal;
        end
    end

    always_ff @(posedge clk_wfi) begin
        pc_o        <= if_pc_i;
        rs1_addr_o  <= rs1;
        rs2_addr_o  <= rs2;
        rs1_data_o  <= rs1_val;
        rs2_data_o  <= rs2_val;
        rd_addr_o   <= if_inst_i[11:7];
        imm_o       <= imm;
        alu_op_o    <= alu_op;
        use_imm_o   <= use_imm;
        branch_ne_o <= funct3[0];
    end
endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic                   wr_i,
    input  logic [`REG_ADDR_W-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]       wr_data_i
);
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is zero, same-cycle write is bypassed to the readers
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wr_i && wr_addr_i == rs1_addr_i) ? wr_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wr_i && wr_addr_i == rs2_addr_i) ? wr_data_i : regs[rs2_addr_i];
endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_unit (
    input  logic             clk_wfi,
    input  logic             rstn_sync,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    output logic [`XLEN-1:0] imem_addr_o,
    input  logic [`XLEN-1:0] imem_rdata_i,
    output logic             if_valid_o,
    output logic [`XLEN-1:0] if_pc_o,
    output logic [`XLEN-1:0] if_inst_o
);
    logic [`XLEN-1:0] pc;

    assign imem_addr_o = pc;

    // PC and IF/ID, redirect wins over the load-use hold
    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            pc         <= `RESET_PC;
            if_valid_o <= 1'b0;
            if_pc_o    <= `RESET_PC;
            if_inst_o  <= `INST_NOP;
        end else if (redirect_i) begin
            pc         <= redirect_pc_i;
            if_valid_o <= 1'b0;
            if_inst_o  <= `INST_NOP;
        end else if (!stall_i) begin
            pc         <= pc + `XLEN'd4;
            if_valid_o <= 1'b1;
            if_pc_o    <= pc;
            if_inst_o  <= imem_rdata_i;
        end
    end
endmodule

// File: verilog/stage_if.sv
`timescale 1ns/1ps
`include "core_defs.svh"

// EX/MEM pipeline register contents
interface stage_if;
    logic                   valid;
    logic                   rd_wr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       result;
    logic                   mem_req;
    logic                   mem_wr;
    logic [`XLEN-1:0]       store_data;

    modport src (
        output valid, rd_wr, rd_addr, result, mem_req, mem_wr, store_data
    );

    modport dst (
        input valid, rd_wr, rd_addr, result, mem_req, mem_wr, store_data
    );
endinterface

// File: verilog/core_pkg.sv
package core_pkg;

    // RV32I major opcodes in scope
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

// File: verilog/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and address width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// First fetch address
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

`endif
